//--- source/acc_execute.sv
// ======================================
// Accumulator execute stage
// Applies each decoded op to the 24-bit
// accumulator and emits the new value
// ======================================

`default_nettype none

module acc_execute (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  // Decoded op input
  input  wire logic             op_valid_i,
  output logic                  op_ready_o,
  input  wire acc_pkg::dec_op_t op_i,
  // Result output
  output logic                  res_valid_o,
  input  wire logic             res_ready_i,
  output acc_pkg::result_t      res_o
);

  import acc_pkg::*;

  logic [ACC_W-1:0] acc_q;
  logic [ACC_W-1:0] acc_next;
  logic [ACC_W-1:0] operand_ext;
  logic             res_valid_q;
  logic             accept;

  // ======================================
  // Accumulator update
  // ======================================

  // Operands are unsigned, so zero extension
  assign operand_ext = ACC_W'(op_i.operand);

  always_comb begin
    if (op_i.load) begin
      acc_next = operand_ext;
    end else begin
      // Sum wraps at the accumulator width
      acc_next = acc_q + operand_ext;
    end
  end

  // ======================================
  // Result stage
  // ======================================

  // Stall while a result is waiting and the egress side is not taking it
  assign op_ready_o = ~res_valid_q | res_ready_i;
  assign accept     = op_valid_i & op_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else if (accept) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  // The accumulator changes only on accept, which is also when a
  // new result is launched, so it doubles as the result register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (accept) begin
      acc_q <= acc_next;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o.acc   = acc_q;

endmodule

`default_nettype wire

//--- source/acc_pipe_top.sv
// ======================================
// Accumulator command pipeline top
// Ingress queue, decode, execute and
// egress queue in a valid/ready chain
// ======================================

`default_nettype none

module acc_pipe_top #(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  // Command input
  input  wire logic             in_valid_i,
  output logic                  in_ready_o,
  input  wire acc_pkg::cmd_t    in_cmd_i,
  // Result output
  output logic                  out_valid_o,
  input  wire logic             out_ready_i,
  output acc_pkg::result_t      out_result_o
);

  import acc_pkg::*;

  // Ingress queue to decode
  logic    ing_valid;
  logic    ing_ready;
  cmd_t    ing_cmd;
  // Decode to execute
  logic    dec_valid;
  logic    dec_ready;
  dec_op_t dec_op;
  // Execute to egress queue
  logic    exe_valid;
  logic    exe_ready;
  result_t exe_res;

  // Flow mode, so an idle pipeline adds no cycle here
  cmd_queue #(
    .T     (cmd_t),
    .DEPTH (QUEUE_DEPTH),
    .FLOW  (1'b1),
    .PIPE  (1'b0)
  ) i_ingress_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .enq_valid_i (in_valid_i),
    .enq_ready_o (in_ready_o),
    .enq_data_i  (in_cmd_i),
    .deq_valid_o (ing_valid),
    .deq_ready_i (ing_ready),
    .deq_data_o  (ing_cmd)
  );

  cmd_decode i_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (ing_valid),
    .cmd_ready_o (ing_ready),
    .cmd_i       (ing_cmd),
    .op_valid_o  (dec_valid),
    .op_ready_i  (dec_ready),
    .op_o        (dec_op)
  );

  acc_execute i_execute (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .op_valid_i  (dec_valid),
    .op_ready_o  (dec_ready),
    .op_i        (dec_op),
    .res_valid_o (exe_valid),
    .res_ready_i (exe_ready),
    .res_o       (exe_res)
  );

  // Pipe mode keeps a full egress queue moving at one result per cycle
  cmd_queue #(
    .T     (result_t),
    .DEPTH (QUEUE_DEPTH),
    .FLOW  (1'b0),
    .PIPE  (1'b1)
  ) i_egress_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .enq_valid_i (exe_valid),
    .enq_ready_o (exe_ready),
    .enq_data_i  (exe_res),
    .deq_valid_o (out_valid_o),
    .deq_ready_i (out_ready_i),
    .deq_data_o  (out_result_o)
  );

endmodule

`default_nettype wire

//--- source/acc_pkg.sv
// ======================================
// Accumulator pipeline shared types
// Opcodes, command word with its payload
// union, decoded op and result word
// ======================================

`default_nettype none

package acc_pkg;

  // Accumulator and result width, wraps modulo 2^ACC_W
  localparam int unsigned ACC_W = 24;

  // ======================================
  // Command word
  // ======================================

  typedef enum logic [1:0] {
    OP_LOAD = 2'd0,
    OP_ADD  = 2'd1,
    OP_MAC  = 2'd2,
    OP_READ = 2'd3
  } opcode_e;

  // Second reading of the payload, fa in the upper byte
  typedef struct packed {
    logic [7:0] fa;
    logic [7:0] fb;
  } factors_t;

  // LOAD and ADD read imm, MAC reads factors
  typedef union packed {
    logic [15:0] imm;
    factors_t    factors;
  } payload_u;

  typedef struct packed {
    opcode_e  opcode;
    payload_u payload;
  } cmd_t;

  // ======================================
  // Decoded op and result
  // ======================================

  // Load replaces the accumulator, otherwise operand is added
  typedef struct packed {
    logic        load;
    logic [15:0] operand;
  } dec_op_t;

  typedef struct packed {
    logic [ACC_W-1:0] acc;
  } result_t;

endpackage

`default_nettype wire

//--- source/cmd_decode.sv
// ======================================
// Command decode stage
// Reads the payload as an immediate or
// as two factors and registers the op
// ======================================

`default_nettype none

module cmd_decode (
  input  wire logic           clk_i,
  input  wire logic           rst_ni,
  // Command input
  input  wire logic           cmd_valid_i,
  output logic                cmd_ready_o,
  input  wire acc_pkg::cmd_t  cmd_i,
  // Decoded op output
  output logic                op_valid_o,
  input  wire logic           op_ready_i,
  output acc_pkg::dec_op_t    op_o
);

  import acc_pkg::*;

  dec_op_t op_next;
  dec_op_t op_q;
  logic    op_valid_q;
  logic    accept;

  // ======================================
  // Payload decode
  // ======================================

  always_comb begin
    op_next = '0;
    case (cmd_i.opcode)
      OP_LOAD: begin
        op_next.load    = 1'b1;
        op_next.operand = cmd_i.payload.imm;
      end
      OP_ADD: begin
        op_next.load    = 1'b0;
        op_next.operand = cmd_i.payload.imm;
      end
      OP_MAC: begin
        // 8x8 product fits the 16-bit operand exactly
        op_next.load    = 1'b0;
        op_next.operand = cmd_i.payload.factors.fa * cmd_i.payload.factors.fb;
      end
      OP_READ: begin
        // Add of zero leaves the accumulator as it is
        op_next.load    = 1'b0;
        op_next.operand = '0;
      end
      default: begin
        op_next = '0;
      end
    endcase
  end

  // ======================================
  // Output register
  // ======================================

  // Free when empty or being drained this cycle
  assign cmd_ready_o = ~op_valid_q | op_ready_i;
  assign accept      = cmd_valid_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_valid_q <= 1'b0;
    end else if (accept) begin
      op_valid_q <= 1'b1;
    end else if (op_ready_i) begin
      op_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= op_next;
    end
  end

  assign op_valid_o = op_valid_q;
  assign op_o       = op_q;

endmodule

`default_nettype wire

//--- source/cmd_queue.sv
// ======================================
// Circular-buffer queue, valid/ready
// FLOW forwards into an empty queue,
// PIPE accepts while a full queue drains
// ======================================

`default_nettype none

module cmd_queue #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 4,
  parameter bit          FLOW  = 1'b0,
  parameter bit          PIPE  = 1'b0
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  // Enqueue side
  input  wire logic enq_valid_i,
  output logic      enq_ready_o,
  input  wire T     enq_data_i,
  // Dequeue side
  output logic      deq_valid_o,
  input  wire logic deq_ready_i,
  output T          deq_data_o
);

  // A single-entry queue still needs a one-bit pointer
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] enq_ptr_q;
  logic [PTR_W-1:0] deq_ptr_q;
  logic [PTR_W-1:0] enq_ptr_next;
  logic [PTR_W-1:0] deq_ptr_next;
  logic             maybe_full_q;
  logic             ptr_match;
  logic             empty;
  logic             full;
  logic             do_enq;
  logic             do_deq;

  // ======================================
  // Status
  // ======================================

  // Matching pointers mean empty or full, maybe_full tells which
  assign ptr_match = (enq_ptr_q == deq_ptr_q);
  assign empty     = ptr_match & ~maybe_full_q;
  assign full      = ptr_match & maybe_full_q;

  // Explicit wrap so any depth works, not only powers of two
  assign enq_ptr_next = (enq_ptr_q == LAST_PTR) ? '0 : enq_ptr_q + 1'b1;
  assign deq_ptr_next = (deq_ptr_q == LAST_PTR) ? '0 : deq_ptr_q + 1'b1;

  // Pipe option: a full queue frees a slot in the cycle it is drained
  assign enq_ready_o = ~full | (PIPE & deq_ready_i);

  // ======================================
  // Output side and transfer decisions
  // ======================================

  always_comb begin
    deq_valid_o = ~empty;
    deq_data_o  = mem_q[deq_ptr_q];
    do_enq      = enq_valid_i & enq_ready_o;
    do_deq      = ~empty & deq_ready_i;
    // Flow option: an empty queue shows the input directly
    if (FLOW && empty) begin
      deq_valid_o = enq_valid_i;
      deq_data_o  = enq_data_i;
      // Consumer took the word this cycle, nothing to store
      if (deq_ready_i) begin
        do_enq = 1'b0;
      end
    end
  end

  // ======================================
  // Pointers and storage
  // ======================================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enq_ptr_q    <= '0;
      deq_ptr_q    <= '0;
      maybe_full_q <= 1'b0;
    end else begin
      if (do_enq) begin
        enq_ptr_q <= enq_ptr_next;
      end
      if (do_deq) begin
        deq_ptr_q <= deq_ptr_next;
      end
      // Occupancy only changes when one side moves alone
      if (do_enq != do_deq) begin
        maybe_full_q <= do_enq;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_enq) begin
      mem_q[enq_ptr_q] <= enq_data_i;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
source/acc_pkg.sv
source/cmd_queue.sv
source/cmd_decode.sv
source/acc_execute.sv
source/acc_pipe_top.sv
verif/tb_clock_gen.sv
verif/tb_acc_pipe.sv

//--- verif/tb_acc_pipe.sv
// ======================================
// Accumulator pipeline testbench
// Table-driven commands, latency and
// back-pressure checks, ordered results
// ======================================

`default_nettype none

module tb_acc_pipe;

  timeunit 1ns;
  timeprecision 1ps;

  import acc_pkg::*;

  localparam int DEPTH          = 4;
  localparam int MAX_INFLIGHT   = 2 * DEPTH + 2;
  localparam int NUM_ROWS       = 15;
  localparam int SEND_TIMEOUT   = 100;
  localparam int DRAIN_TIMEOUT  = 200;
  localparam int RESET_TIMEOUT  = 20;
  localparam int IDLE_LATENCY   = 3;

  // One table row, repeated reps times, exp_acc is the value after the last
  typedef struct packed {
    opcode_e     op;
    logic [15:0] payload;
    logic [15:0] reps;
    logic [23:0] exp_acc;
  } row_t;

  row_t rows [NUM_ROWS] = '{
    '{OP_LOAD, 16'h1234, 16'd1,   24'h001234},
    '{OP_ADD,  16'h0001, 16'd1,   24'h001235},
    '{OP_READ, 16'hBEEF, 16'd1,   24'h001235},
    '{OP_MAC,  16'hFFFF, 16'd1,   24'h011036},
    '{OP_MAC,  16'h007B, 16'd1,   24'h011036},
    '{OP_MAC,  16'h1200, 16'd1,   24'h011036},
    '{OP_MAC,  16'h0305, 16'd1,   24'h011045},
    '{OP_LOAD, 16'hFFFF, 16'd1,   24'h00FFFF},
    '{OP_ADD,  16'hFFFF, 16'd256, 24'h00FEFF},
    '{OP_ADD,  16'h0101, 16'd1,   24'h010000},
    '{OP_MAC,  16'h8081, 16'd1,   24'h014080},
    '{OP_READ, 16'h0000, 16'd1,   24'h014080},
    '{OP_LOAD, 16'h0010, 16'd1,   24'h000010},
    '{OP_ADD,  16'h0001, 16'd14,  24'h00001E},
    '{OP_MAC,  16'h0202, 16'd1,   24'h000022}
  };

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  cmd_t        in_cmd;
  logic        out_valid;
  logic        out_ready;
  result_t     out_result;

  cmd_t        cmd_list [$];
  logic [23:0] exp_list [$];
  int          tx_cycle [$];
  int          rx_cycle [$];
  int          row_start [NUM_ROWS + 1];
  int          rx_count   = 0;
  int          cycle_cnt  = 0;
  int          ready_mode = 0;
  logic [31:0] lcg_state  = 32'd80;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  acc_pipe_top #(
    .QUEUE_DEPTH (DEPTH)
  ) i_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .in_valid_i   (in_valid),
    .in_ready_o   (in_ready),
    .in_cmd_i     (in_cmd),
    .out_valid_o  (out_valid),
    .out_ready_i  (out_ready),
    .out_result_o (out_result)
  );

  // ======================================
  // Reference model and helpers
  // ======================================

  function automatic logic [23:0] model_acc(input logic [23:0] acc, input opcode_e op,
                                            input logic [15:0] payload);
    logic [15:0] prod;
    prod = payload[15:8] * payload[7:0];
    case (op)
      OP_LOAD: return {8'h00, payload};
      OP_ADD:  return acc + {8'h00, payload};
      OP_MAC:  return acc + {8'h00, prod};
      default: return acc;
    endcase
  endfunction

  // Low LCG bits have short periods, so output comes from the upper half
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_failed();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic fail_with(input string reason);
    $display("ERROR at time %0t: %s", $time, reason);
    stop_failed();
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at time %0t: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      stop_failed();
    end
  endtask

  // Expand the table and cross-check the model against each row
  task automatic build_commands();
    logic [23:0] acc;
    cmd_t        cmd;
    acc = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_start[r] = cmd_list.size();
      for (int k = 0; k < int'(rows[r].reps); k++) begin
        cmd.opcode      = rows[r].op;
        cmd.payload.imm = rows[r].payload;
        acc = model_acc(acc, rows[r].op, rows[r].payload);
        cmd_list.push_back(cmd);
        exp_list.push_back(acc);
      end
      check_value(acc, rows[r].exp_acc, $sformatf("model against table row %0d", r));
    end
    row_start[NUM_ROWS] = cmd_list.size();
  endtask

  // ======================================
  // Clock-side processes
  // ======================================

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #2;
      case (ready_mode)
        0: out_ready = 1'b1;
        1: begin
          lcg_state = lcg_next(lcg_state);
          out_ready = lcg_state[16];
        end
        default: out_ready = 1'b0;
      endcase
    end
  end

  // Results must come back once each and in command order
  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (rx_count >= cmd_list.size()) begin
        fail_with("a result arrived with no command outstanding");
      end else begin
        check_value(out_result.acc, exp_list[rx_count], $sformatf("result %0d", rx_count));
        rx_cycle.push_back(cycle_cnt);
        rx_count <= rx_count + 1;
      end
    end
  end

  // ======================================
  // Driver tasks
  // ======================================

  task automatic set_ready_mode(input int mode);
    @(posedge clk);
    ready_mode = mode;
    #2;
  endtask

  task automatic wait_reset();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1) begin
      if (waited == RESET_TIMEOUT) fail_with("reset was never released");
      @(posedge clk);
      waited++;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic send_range(input int first, input int last);
    int waited;
    bit accepted;
    for (int i = first; i <= last; i++) begin
      in_valid = 1'b1;
      in_cmd   = cmd_list[i];
      waited   = 0;
      accepted = 1'b0;
      while (!accepted) begin
        @(posedge clk);
        if (in_ready) begin
          accepted = 1'b1;
          tx_cycle.push_back(cycle_cnt);
        end else if (waited == SEND_TIMEOUT) begin
          fail_with($sformatf("command %0d was not accepted in time", i));
        end
        waited++;
        #2;
      end
    end
    in_valid = 1'b0;
  endtask

  // Leaves the stalled command on the input with valid held high
  task automatic fill_until_stall(input int first, input int last, output int next_idx);
    int  accepted;
    bit  stalled;
    accepted = 0;
    stalled  = 1'b0;
    next_idx = first;
    while (!stalled) begin
      if (next_idx > last) fail_with("ran out of commands before in_ready_o dropped");
      if (accepted > MAX_INFLIGHT) fail_with("in_ready_o stayed high past the in-flight limit");
      in_valid = 1'b1;
      in_cmd   = cmd_list[next_idx];
      @(posedge clk);
      if (in_ready) begin
        tx_cycle.push_back(cycle_cnt);
        accepted++;
        next_idx++;
      end else begin
        stalled = 1'b1;
      end
      #2;
    end
  endtask

  task automatic wait_results(input int target);
    int waited;
    waited = 0;
    while (rx_count < target) begin
      if (waited == DRAIN_TIMEOUT) begin
        fail_with($sformatf("only %0d of %0d results arrived", rx_count, target));
      end
      @(posedge clk);
      #2;
      waited++;
    end
  endtask

  // ======================================
  // Main sequence
  // ======================================

  initial begin
    int next_idx;
    int held;
    in_valid = 1'b0;
    in_cmd   = '0;
    build_commands();
    wait_reset();
    check_value(out_valid, 1'b0, "out_valid_o after reset");
    check_value(in_ready, 1'b1, "in_ready_o after reset");

    // Phase one, single command then a back-to-back burst
    send_range(0, 0);
    wait_results(1);
    send_range(row_start[1], row_start[8] - 1);
    wait_results(row_start[8]);
    for (int i = 0; i < row_start[8]; i++) begin
      check_value(rx_cycle[i] - tx_cycle[i], IDLE_LATENCY, $sformatf("latency of %0d", i));
      if (i > 1) begin
        check_value(tx_cycle[i] - tx_cycle[i-1], 1, $sformatf("issue gap before %0d", i));
      end
    end

    // Phase two, random back-pressure across the wrap
    set_ready_mode(1);
    send_range(row_start[8], row_start[12] - 1);
    wait_results(row_start[12]);
    check_value(rx_count, tx_cycle.size(), "accepted against received count");

    // Phase three, output blocked until the input side stalls
    set_ready_mode(2);
    fill_until_stall(row_start[12], row_start[NUM_ROWS] - 1, next_idx);
    held = next_idx - row_start[12];
    check_value(rx_count, row_start[12], "results delivered while out_ready_i low");
    check_value(held > 0, 1'b1, "commands accepted before the stall");
    check_value(out_valid, 1'b1, "out_valid_o with results held");
    set_ready_mode(0);
    send_range(next_idx, row_start[NUM_ROWS] - 1);
    wait_results(row_start[NUM_ROWS]);
    check_value(out_valid, 1'b0, "out_valid_o after the final drain");

    if (rx_count == cmd_list.size() && tx_cycle.size() == cmd_list.size()) begin
      $display("Held %0d commands at the stall, %0d results checked", held, rx_count);
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_with("command and result counts do not match at the end");
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
// ======================================
// Testbench clock and reset source
// 40 ns clock, reset low for 8 cycles
// ======================================

`default_nettype none

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 40,
  parameter int unsigned RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #(PERIOD_NS / 4);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire
